//--- dclk.f
rtl/dclk_pkg.sv
rtl/dclk_ctrl_if.sv
rtl/tick_gen.sv
rtl/button_sync.sv
rtl/mode_ctrl.sv
rtl/timekeeper.sv
rtl/display_scan.sv
rtl/dclk_top.sv
test/tb_dclk.sv

//--- Makefile
# Verilator build and run for the digital clock testbench.
# Any variable can be overridden on the command line, e.g.
#   make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_dclk
FILELIST  ?= dclk.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_dclk.sv
/*
 * Self-checking testbench for the six-digit digital clock.
 * Drives the four buttons, reads the scanned display back into a time
 * value and compares it with a reference model of the clock rules.
 * Small divisors make one simulated second 2000 clocks long.
 */

`timescale 1ns/1ns

module tb_dclk;

	import dclk_pkg::*;

	localparam int CLKS_PER_SEC      = 2000;
	localparam int CLKS_PER_SCAN     = 8;
	localparam int CLKS_PER_DEBOUNCE = 16;
	localparam int CLKS_PER_BLINK    = 400;
	localparam int SEED              = 51912;
	localparam int HOLD_CYCLES       = 4 * CLKS_PER_DEBOUNCE;
	localparam int READ_TIMEOUT      = 6 * CLKS_PER_BLINK;

	// One-hot button masks, {alarm, inc, pos, mode}
	localparam logic [3:0] PRESS_MODE  = 4'b0001;
	localparam logic [3:0] PRESS_POS   = 4'b0010;
	localparam logic [3:0] PRESS_INC   = 4'b0100;
	localparam logic [3:0] PRESS_ALARM = 4'b1000;

	// Segments a..g with a as MSB
	localparam logic [6:0] SEG_TABLE [10] = '{
		7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33,
		7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h73
	};

	logic       clk;
	logic       rst_n;
	logic       btn_mode;
	logic       btn_pos;
	logic       btn_inc;
	logic       btn_alarm;
	logic [6:0] seg;
	logic       seg_dp;
	logic [5:0] seg_enb;
	logic       alarm;

	// Sampler results, stamped with the cycle count
	logic [6:0] seg_seen [6];
	logic [5:0] dp_seen;
	int         seen_at [6];
	int         blank_count;

	int cyc;
	int errors;
	int timeouts;

	dclk_top #(
		.CLKS_PER_SEC      (CLKS_PER_SEC),
		.CLKS_PER_SCAN     (CLKS_PER_SCAN),
		.CLKS_PER_DEBOUNCE (CLKS_PER_DEBOUNCE),
		.CLKS_PER_BLINK    (CLKS_PER_BLINK)
	) dclk_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn_mode),
		.i_btn_pos   (btn_pos),
		.i_btn_inc   (btn_inc),
		.i_btn_alarm (btn_alarm),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	always #20 clk = ~clk;

	// Cycles since reset release
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	// ------------------------------------------------------------------
	// Display sampler
	// ------------------------------------------------------------------
	always @(negedge clk) begin : sampler
		logic [2:0] k;
		if (rst_n) begin
			for (k = 0; k < 3'd6; k++) begin
				if ($countones(~seg_enb) == 1 && !seg_enb[k]) begin
					seg_seen[k] <= seg;
					dp_seen[k]  <= seg_dp;
					seen_at[k]  <= cyc;
				end
			end
			if (seg_enb == 6'h3f) begin
				blank_count <= blank_count + 1;
			end
		end
	end

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------
	// Second tick with carries when step is 0, single field step otherwise
	function automatic hms_t next_time(input hms_t t, input bit step, input int pos);
		hms_t r;
		r = t;
		if (step) begin
			case (pos)
				0:       r.sec  = (t.sec == 6'd59) ? 6'd0 : t.sec + 6'd1;
				1:       r.min  = (t.min == 6'd59) ? 6'd0 : t.min + 6'd1;
				default: r.hour = (t.hour == 6'd23) ? 6'd0 : t.hour + 6'd1;
			endcase
		end else begin
			r.sec = (t.sec == 6'd59) ? 6'd0 : t.sec + 6'd1;
			if (t.sec == 6'd59) begin
				r.min = (t.min == 6'd59) ? 6'd0 : t.min + 6'd1;
				if (t.min == 6'd59) begin
					r.hour = (t.hour == 6'd23) ? 6'd0 : t.hour + 6'd1;
				end
			end
		end
		return r;
	endfunction

	function automatic int seg_to_digit(input logic [6:0] pattern);
		int d;
		logic [3:0] i;
		d = -1;
		for (i = 0; i < 4'd10; i++) begin
			if (SEG_TABLE[i] == pattern) begin
				d = int'(i);
			end
		end
		return d;
	endfunction

	function automatic int total_secs(input hms_t t);
		return int'(t.hour) * 3600 + int'(t.min) * 60 + int'(t.sec);
	endfunction

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	task automatic finish_run();
		$display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		timeouts++;
	endtask

	task automatic compare_time(input hms_t got, input hms_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t: %s shows %0d:%0d:%0d, expected %0d:%0d:%0d", $time, what,
				got.hour, got.min, got.sec, exp.hour, exp.min, exp.sec);
			errors++;
		end
	endtask

	task automatic verify_dp(input logic [5:0] got, input logic [5:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t: %s are %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// Hold for four debounce periods, then release for four
	task automatic press_button(input logic [3:0] mask);
		{btn_alarm, btn_inc, btn_pos, btn_mode} = mask;
		repeat (HOLD_CYCLES) @(negedge clk);
		{btn_alarm, btn_inc, btn_pos, btn_mode} = 4'b0000;
		repeat (HOLD_CYCLES) @(negedge clk);
	endtask

	task automatic read_display(output hms_t t, output logic [5:0] dp);
		int start;
		int n;
		int d [6];
		bit done;
		logic [2:0] k;
		start = cyc;
		n = 0;
		done = 1'b0;
		t = '0;
		while (!done && n < READ_TIMEOUT) begin
			@(negedge clk);
			n++;
			done = 1'b1;
			for (k = 0; k < 3'd6; k++) begin
				if (seen_at[k] <= start) begin
					done = 1'b0;
				end
			end
		end
		dp = dp_seen;
		if (!done) begin
			report_timeout("the display scan did not show all six digits");
		end else begin
			for (k = 0; k < 3'd6; k++) begin
				d[k] = seg_to_digit(seg_seen[k]);
				if (d[k] < 0) begin
					$display("FAIL at %0t: digit %0d shows unknown pattern %b", $time, k,
						seg_seen[k]);
					errors++;
					d[k] = 0;
				end
			end
			t.sec  = 6'(d[1] * 10 + d[0]);
			t.min  = 6'(d[3] * 10 + d[2]);
			t.hour = 6'(d[5] * 10 + d[4]);
		end
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	// Stops early once a wait has run out
	task automatic run_sequence();
		hms_t       shown;
		hms_t       model;
		hms_t       target;
		logic [5:0] dp;
		int         n;
		int         secs;
		int         est;
		int         presses;
		bit         fell;

		// Reset state
		if (alarm !== 1'b0) begin
			$display("FAIL at %0t: o_alarm is %b after reset", $time, alarm);
			errors++;
		end
		read_display(shown, dp);
		if (timeouts > 0) begin
			return;
		end
		compare_time(shown, '0, "display after reset");
		verify_dp(dp, 6'b000000, "clock mode decimal points");

		// Free-running clock against elapsed cycles
		n = $urandom_range(8, 3);
		repeat (n * CLKS_PER_SEC) @(negedge clk);
		read_display(shown, dp);
		if (timeouts > 0) begin
			return;
		end
		secs = cyc / CLKS_PER_SEC;
		if (total_secs(shown) != secs && total_secs(shown) != secs - 1) begin
			$display("FAIL at %0t: clock shows %0d s after %0d cycles", $time,
				total_secs(shown), cyc);
			errors++;
		end

		// Setup mode, time frozen while fields are stepped
		press_button(PRESS_MODE);
		read_display(model, dp);
		if (timeouts > 0) begin
			return;
		end
		verify_dp(dp, 6'b000001, "setup mode decimal points");
		for (int pos = 0; pos < 3; pos++) begin
			n = $urandom_range(70, 0);
			repeat (n) begin
				press_button(PRESS_INC);
				model = next_time(model, 1'b1, pos);
			end
			press_button(PRESS_POS);
		end
		read_display(shown, dp);
		if (timeouts > 0) begin
			return;
		end
		compare_time(shown, model, "time after setup steps");
		repeat (CLKS_PER_SEC + CLKS_PER_SEC / 10) @(negedge clk);
		read_display(shown, dp);
		if (timeouts > 0) begin
			return;
		end
		compare_time(shown, model, "time held in setup mode");
		n = blank_count;
		repeat (4 * CLKS_PER_BLINK) @(negedge clk);
		if (blank_count == n) begin
			$display("FAIL at %0t: selected field never blanked in setup mode", $time);
			errors++;
		end

		// Alarm mode, the clock keeps running
		press_button(PRESS_MODE);
		read_display(shown, dp);
		if (timeouts > 0) begin
			return;
		end
		verify_dp(dp, 6'b000010, "alarm mode decimal points");
		// Start early in a minute so the target keeps its minute
		if (shown.sec >= 6'd20) begin
			repeat ((60 - int'(shown.sec)) * CLKS_PER_SEC) @(negedge clk);
			read_display(shown, dp);
			if (timeouts > 0) begin
				return;
			end
		end
		// Target is three seconds after the alarm gets armed
		est = 0;
		target = shown;
		repeat (3) begin
			target = shown;
			repeat (3 + est) begin
				target = next_time(target, 1'b0, 0);
			end
			presses = int'(target.sec) + int'(target.min) + int'(target.hour) + 5;
			est = (presses * 2 * HOLD_CYCLES + CLKS_PER_SEC - 1) / CLKS_PER_SEC;
		end
		repeat (int'(target.sec)) press_button(PRESS_INC);
		press_button(PRESS_POS);
		repeat (int'(target.min)) press_button(PRESS_INC);
		press_button(PRESS_POS);
		repeat (int'(target.hour)) press_button(PRESS_INC);
		press_button(PRESS_POS);
		press_button(PRESS_ALARM);
		press_button(PRESS_MODE);

		n = 0;
		while (!alarm && n < 6 * CLKS_PER_SEC) begin
			@(negedge clk);
			n++;
		end
		if (!alarm) begin
			report_timeout("o_alarm did not rise within 6 seconds");
			return;
		end
		read_display(shown, dp);
		if (timeouts > 0) begin
			return;
		end
		compare_time(shown, target, "time when the alarm went off");
		verify_dp(dp, 6'b000000, "clock mode decimal points");

		// Disarm and watch the alarm drop during the press
		fell = 1'b0;
		btn_alarm = 1'b1;
		for (n = 0; n < HOLD_CYCLES; n++) begin
			@(negedge clk);
			if (!alarm) begin
				fell = 1'b1;
			end
		end
		btn_alarm = 1'b0;
		repeat (HOLD_CYCLES) @(negedge clk);
		if (!fell) begin
			$display("FAIL at %0t: o_alarm still high after the disarm press", $time);
			errors++;
		end
	endtask

	initial begin : main
		void'($urandom(SEED));
		clk = 1'b0;
		rst_n = 1'b0;
		{btn_alarm, btn_inc, btn_pos, btn_mode} = 4'b0000;
		errors = 0;
		timeouts = 0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		run_sequence();
		finish_run();
	end

endmodule

//--- rtl/dclk_top.sv
/*
 * Digital clock top level. One clock domain: tick generators for the
 * second, scan and debounce rates feed the button front end, mode
 * controller, timekeeper and display scanner.
 */

`timescale 1ns/1ns

module dclk_top #(
	parameter int unsigned CLKS_PER_SEC      = dclk_pkg::DEF_CLKS_PER_SEC,
	parameter int unsigned CLKS_PER_SCAN     = dclk_pkg::DEF_CLKS_PER_SCAN,
	parameter int unsigned CLKS_PER_DEBOUNCE = dclk_pkg::DEF_CLKS_PER_DEBOUNCE,
	parameter int unsigned CLKS_PER_BLINK    = dclk_pkg::DEF_CLKS_PER_BLINK
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_btn_mode,
	input  logic                           i_btn_pos,
	input  logic                           i_btn_inc,
	input  logic                           i_btn_alarm,
	output logic [dclk_pkg::SEG_W-1:0]      o_seg,
	output logic                           o_seg_dp,
	output logic [dclk_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic                           o_alarm
);

	import dclk_pkg::*;

	logic                 sec_tick;
	logic                 scan_tick;
	logic                 deb_tick;
	logic [BTN_COUNT-1:0] press;
	hms_t                 cur_time;

	dclk_ctrl_if ctrl_if ();

	// ------------------------------------------------------------------
	// Rate ticks
	// ------------------------------------------------------------------
	tick_gen #(.DIVIDE (CLKS_PER_SEC)) sec_tick_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIVIDE (CLKS_PER_SCAN)) scan_tick_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	tick_gen #(.DIVIDE (CLKS_PER_DEBOUNCE)) deb_tick_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (deb_tick)
	);

	// Bit order follows the BTN_* indices
	button_sync button_sync_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (deb_tick),
		.i_btn    ({i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode}),
		.o_press  (press)
	);

	mode_ctrl mode_ctrl_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_press (press),
		.ctrl    (ctrl_if.ctrl)
	);

	timekeeper timekeeper_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sec_tick (sec_tick),
		.ctrl       (ctrl_if.keeper),
		.o_time     (cur_time),
		.o_alarm    (o_alarm)
	);

	display_scan #(
		.CLKS_PER_BLINK (CLKS_PER_BLINK)
	) display_scan_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_time      (cur_time),
		.ctrl        (ctrl_if.view),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

//--- rtl/display_scan.sv
/*
 * Multiplexed display driver for six common-node digits. A scan
 * counter walks digits 0..5 (sec ones up to hour tens) on the scan
 * tick. The selected field is split into tens and ones and decoded to
 * segments. In setup mode the selected field blinks, and the decimal
 * points show the mode code.
 */

`timescale 1ns/1ns

module display_scan #(
	parameter int unsigned CLKS_PER_BLINK = dclk_pkg::DEF_CLKS_PER_BLINK
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_scan_tick,
	input  dclk_pkg::hms_t                 i_time,
	dclk_ctrl_if.view                      ctrl,
	output logic [dclk_pkg::SEG_W-1:0]      o_seg,
	output logic                           o_seg_dp,
	output logic [dclk_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	import dclk_pkg::*;

	localparam int DIG_W = $clog2(NUM_DIGITS);

	logic                  blink_tick;
	logic                  blink_q;
	logic [DIG_W-1:0]      digit_q;
	logic [1:0]            field_sel;
	logic [5:0]            field_val;
	logic [3:0]            digit_val;
	logic [NUM_DIGITS-1:0] dp_map;

	tick_gen #(
		.DIVIDE (CLKS_PER_BLINK)
	) blink_tick_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (blink_tick)
	);

	// ------------------------------------------------------------------
	// Blink phase and digit scan
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blink_q <= 1'b0;
			digit_q <= '0;
		end else begin
			if (blink_tick) begin
				blink_q <= ~blink_q;
			end
			if (i_scan_tick) begin
				if (digit_q == DIG_W'(NUM_DIGITS - 1)) begin
					digit_q <= '0;
				end else begin
					digit_q <= digit_q + 1'b1;
				end
			end
		end
	end

	// Two digits per field, same order as pos_e
	assign field_sel = digit_q[DIG_W-1:1];

	always_comb begin
		case (field_sel)
			2'd0:    field_val = i_time.sec;
			2'd1:    field_val = i_time.min;
			default: field_val = i_time.hour;
		endcase
	end

	// Odd digits carry the tens
	assign digit_val = digit_q[0] ? 4'(field_val / 6'd10) : 4'(field_val % 6'd10);
	assign o_seg     = seg_decode(digit_val);

	always_comb begin
		if (ctrl.mode == MODE_SETUP && blink_q && field_sel == ctrl.position) begin
			o_seg_enb = '1;
		end else begin
			o_seg_enb = ~(NUM_DIGITS'(1) << digit_q);
		end
	end

	assign dp_map   = NUM_DIGITS'(ctrl.mode);
	assign o_seg_dp = dp_map[digit_q];

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(~o_seg_enb));

endmodule

//--- rtl/timekeeper.sv
/*
 * Time of day and alarm registers. The time runs on the second tick
 * with carries sec -> min -> hour, except in setup mode where it is
 * frozen and inc steps the selected field. In alarm mode inc steps
 * the selected alarm field instead. o_alarm latches a match while
 * the alarm is enabled.
 */

`timescale 1ns/1ns

module timekeeper (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           i_sec_tick,
	dclk_ctrl_if.keeper    ctrl,
	output dclk_pkg::hms_t o_time,
	output logic           o_alarm
);

	import dclk_pkg::*;

	hms_t time_q;
	hms_t time_nxt;
	hms_t alarm_q;
	hms_t alarm_nxt;

	function automatic logic [5:0] wrap_inc(input logic [5:0] val, input logic [5:0] lim);
		return (val >= lim) ? 6'd0 : val + 6'd1;
	endfunction

	// Step one field, no carry into the next
	function automatic hms_t step_field(input hms_t t, input pos_e pos);
		hms_t r;
		r = t;
		case (pos)
			POS_SEC:  r.sec  = wrap_inc(t.sec, MAX_SEC);
			POS_MIN:  r.min  = wrap_inc(t.min, MAX_MIN);
			POS_HOUR: r.hour = wrap_inc(t.hour, MAX_HOUR);
			default:  r = t;
		endcase
		return r;
	endfunction

	// ------------------------------------------------------------------
	// Next-state logic
	// ------------------------------------------------------------------
	always_comb begin
		time_nxt = time_q;
		if (ctrl.mode == MODE_SETUP) begin
			if (ctrl.inc) begin
				time_nxt = step_field(time_q, ctrl.position);
			end
		end else if (i_sec_tick) begin
			time_nxt.sec = wrap_inc(time_q.sec, MAX_SEC);
			if (time_q.sec == MAX_SEC) begin
				time_nxt.min = wrap_inc(time_q.min, MAX_MIN);
				if (time_q.min == MAX_MIN) begin
					time_nxt.hour = wrap_inc(time_q.hour, MAX_HOUR);
				end
			end
		end
	end

	always_comb begin
		alarm_nxt = alarm_q;
		if (ctrl.mode == MODE_ALARM && ctrl.inc) begin
			alarm_nxt = step_field(alarm_q, ctrl.position);
		end
	end

	// ------------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_q  <= '0;
			alarm_q <= '0;
			o_alarm <= 1'b0;
		end else begin
			time_q  <= time_nxt;
			alarm_q <= alarm_nxt;
			// Holds until the alarm is disabled
			o_alarm <= ctrl.alarm_en & (o_alarm | (time_q == alarm_q));
		end
	end

	assign o_time = time_q;

	a_fields_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		time_q.sec <= MAX_SEC && time_q.min <= MAX_MIN && time_q.hour <= MAX_HOUR
		&& alarm_q.sec <= MAX_SEC && alarm_q.min <= MAX_MIN
		&& alarm_q.hour <= MAX_HOUR);

endmodule

//--- rtl/mode_ctrl.sv
/*
 * Mode controller. Turns button presses into the control bundle:
 * mode cycles clock/setup/alarm, position cycles sec/min/hour, the
 * alarm button toggles alarm enable and the step button is passed
 * on as a registered inc pulse.
 */

`timescale 1ns/1ns

module mode_ctrl (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [dclk_pkg::BTN_COUNT-1:0] i_press,
	dclk_ctrl_if.ctrl                     ctrl
);

	import dclk_pkg::*;

	mode_e mode_q;
	pos_e  pos_q;
	logic  alarm_en_q;
	logic  inc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			alarm_en_q <= 1'b0;
			inc_q      <= 1'b0;
		end else begin
			if (i_press[BTN_MODE]) begin
				case (mode_q)
					MODE_CLOCK: mode_q <= MODE_SETUP;
					MODE_SETUP: mode_q <= MODE_ALARM;
					default:    mode_q <= MODE_CLOCK;
				endcase
			end
			if (i_press[BTN_POS]) begin
				case (pos_q)
					POS_SEC: pos_q <= POS_MIN;
					POS_MIN: pos_q <= POS_HOUR;
					default: pos_q <= POS_SEC;
				endcase
			end
			if (i_press[BTN_ALARM]) begin
				alarm_en_q <= ~alarm_en_q;
			end
			inc_q <= i_press[BTN_INC];
		end
	end

	assign ctrl.mode     = mode_q;
	assign ctrl.position = pos_q;
	assign ctrl.alarm_en = alarm_en_q;
	assign ctrl.inc      = inc_q;

	// Encoding 3 is never reachable
	a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.mode inside {MODE_CLOCK, MODE_SETUP, MODE_ALARM});

endmodule

//--- rtl/button_sync.sv
/*
 * Button front end. Raw levels pass a two-flop synchronizer, then the
 * stable value is sampled on each debounce tick into two stages. A
 * 0 -> 1 step between the stages gives a one-cycle press pulse in the
 * clock after the sample.
 */

`timescale 1ns/1ns

module button_sync (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_sample,
	input  logic [dclk_pkg::BTN_COUNT-1:0] i_btn,
	output logic [dclk_pkg::BTN_COUNT-1:0] o_press
);

	import dclk_pkg::*;

	logic [BTN_COUNT-1:0] sync_1;
	logic [BTN_COUNT-1:0] sync_2;
	logic [BTN_COUNT-1:0] samp_cur;
	logic [BTN_COUNT-1:0] samp_prev;
	logic                 sample_d;

	// Metastability guard, runs every clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_1 <= i_btn;
			sync_2 <= sync_1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_cur  <= '0;
			samp_prev <= '0;
			sample_d  <= 1'b0;
			o_press   <= '0;
		end else begin
			sample_d <= i_sample;
			if (i_sample) begin
				samp_cur  <= sync_2;
				samp_prev <= samp_cur;
			end
			// Edge only counts in the cycle right after a sample
			o_press <= sample_d ? (samp_cur & ~samp_prev) : '0;
		end
	end

	a_press_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(o_press & $past(o_press)) == '0);

endmodule

//--- rtl/tick_gen.sv
/*
 * Enable tick generator. Counts system clocks and raises o_tick for a
 * single cycle every DIVIDE cycles, first pulse DIVIDE cycles after
 * reset release. Used for the second, scan, debounce and blink rates.
 */

`timescale 1ns/1ns

module tick_gen #(
	parameter int unsigned DIVIDE = 10
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CNT_W'(DIVIDE - 1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

	// Tick must drop right after it rises
	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
		o_tick |=> !o_tick);

endmodule

//--- rtl/dclk_ctrl_if.sv
/*
 * Control bundle from the mode controller to the timekeeper and the
 * display. The controller drives everything; the timekeeper listens
 * to all of it and the display only needs mode and field position.
 */

`timescale 1ns/1ns

interface dclk_ctrl_if;
	import dclk_pkg::*;

	mode_e mode;
	pos_e  position;
	// One-cycle step request
	logic  inc;
	logic  alarm_en;

	modport ctrl (output mode, output position, output inc, output alarm_en);

	modport keeper (input mode, input position, input inc, input alarm_en);

	modport view (input mode, input position);

endinterface

//--- rtl/dclk_pkg.sv
/*
 * Shared definitions for the six-digit digital clock.
 * Holds the mode and field enums, the time struct, counter limits,
 * display sizes, button indices, default tick divisors and the
 * 7-segment decoder. Modules pull it in with a wildcard import.
 */

package dclk_pkg;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_e;

	// Binary fields, six bits each
	typedef struct packed {
		logic [5:0] hour;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	localparam logic [5:0] MAX_SEC  = 6'd59;
	localparam logic [5:0] MAX_MIN  = 6'd59;
	localparam logic [5:0] MAX_HOUR = 6'd23;

	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;

	// Button vector layout
	localparam int BTN_COUNT = 4;
	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	// Defaults for a 50 MHz board clock
	localparam int unsigned DEF_CLKS_PER_SEC      = 32'd50_000_000;
	localparam int unsigned DEF_CLKS_PER_SCAN     = 32'd5_000;
	localparam int unsigned DEF_CLKS_PER_DEBOUNCE = 32'd500_000;
	localparam int unsigned DEF_CLKS_PER_BLINK    = 32'd25_000_000;

	// Active-high segments {a,b,c,d,e,f,g}, blank for non-decimal input
	function automatic logic [SEG_W-1:0] seg_decode(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b111_1110;
			4'd1: return 7'b011_0000;
			4'd2: return 7'b110_1101;
			4'd3: return 7'b111_1001;
			4'd4: return 7'b011_0011;
			4'd5: return 7'b101_1011;
			4'd6: return 7'b101_1111;
			4'd7: return 7'b111_0000;
			4'd8: return 7'b111_1111;
			4'd9: return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

endpackage
